// File: bench/tb_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_system;

	localparam int line_clocks = 381 * 4;
	localparam int frame_clocks = 381 * 262 * 4;

	logic clk_24;
	logic arst_n;
	logic ce_6;
	logic pause;
	logic menu;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dout;
	logic cpu_wr_n;
	logic [191:0] joystick;
	logic [47:0] paddle;
	logic [10:0] ps2_key;
	logic [32:0] timestamp;
	logic [7:0] cpu_din;
	logic cpu_wait;
	logic vga_hs;
	logic vga_vs;
	logic vga_hb;
	logic vga_vb;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	logic [1:0] ce_phase;
	integer seed;
	logic [7:0] ram_model [0:16383];
	logic [15:0] ram_addrs [0:31];

	system i_system (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.ce_6(ce_6),
		.pause(pause),
		.menu(menu),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_wr_n(cpu_wr_n),
		.joystick(joystick),
		.paddle(paddle),
		.ps2_key(ps2_key),
		.timestamp(timestamp),
		.cpu_din(cpu_din),
		.cpu_wait(cpu_wait),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_hb(vga_hb),
		.vga_vb(vga_vb),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever
			#4 clk_24 = ~clk_24;
	end

	// Pixel enable on one clock in four
	initial
	begin
		ce_phase = 2'd0;
		ce_6 = 1'b0;
		forever
		begin
			@(posedge clk_24);
			#1;
			ce_phase = ce_phase + 2'd1;
			ce_6 = ce_phase == 2'd3;
		end
	end

	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic tick();
		@(posedge clk_24);
		#1;
	endtask

	task automatic write_bus(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_dout = data;
		cpu_wr_n = 1'b0;
		tick();
		cpu_wr_n = 1'b1;
	endtask

	// cpu_din shows the byte for the address seen at the previous edge
	task automatic read_bus(input logic [15:0] addr, output logic [7:0] data);
		cpu_addr = addr;
		cpu_wr_n = 1'b1;
		tick();
		data = cpu_din;
	endtask

	task automatic expect_read(input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		read_bus(addr, got);
		check_hex($sformatf("cpu_din at %h", addr), {24'd0, got}, {24'd0, exp});
	endtask

	function automatic logic [7:0] byte_at(input logic [255:0] word, input int idx);
		return word[idx*8 +: 8];
	endfunction

	task automatic compare_word_bytes(input logic [15:0] base, input logic [255:0] word,
		input int nbytes);
		for (int k = 0; k < nbytes; k++)
			expect_read(base + 16'(k), byte_at(word, k));
	endtask

	task automatic ram_readback();
		logic [31:0] rnd;
		logic [15:0] addr;
		for (int n = 0; n < 32; n++)
		begin
			rnd = $random(seed);
			addr = {2'b11, rnd[13:0]};
			ram_addrs[n] = addr;
			// Later writes to a repeated address replace the earlier byte
			ram_model[addr[13:0]] = rnd[23:16];
			write_bus(addr, rnd[23:16]);
		end
		for (int n = 0; n < 32; n++)
			expect_read(ram_addrs[n], ram_model[ram_addrs[n][13:0]]);
	endtask

	task automatic input_map_reads();
		logic [31:0] rnd;
		logic [7:0] got;
		for (int i = 0; i < 6; i++)
			joystick[i*32 +: 32] = $random(seed);
		paddle[31:0] = $random(seed);
		rnd = $random(seed);
		paddle[47:32] = rnd[15:0];
		rnd = $random(seed);
		ps2_key = rnd[10:0];
		timestamp[31:0] = $random(seed);
		rnd = $random(seed);
		timestamp[32] = rnd[0];
		compare_word_bytes(16'h803A, {64'd0, joystick}, 24);
		compare_word_bytes(16'h81BA, {208'd0, paddle}, 6);
		compare_word_bytes(16'h824A, {245'd0, ps2_key}, 2);
		compare_word_bytes(16'h8002, {223'd0, timestamp}, 5);
		// Status byte constants and the idle debug bit
		read_bus(16'h8000, got);
		check_hex("cpu_din[3:2]", {30'd0, got[3:2]}, 32'd2);
		check_hex("cpu_din[0]", {31'd0, got[0]}, 32'd0);
		expect_read(16'h8001, 8'h00);
		expect_read(16'h4000, 8'h00);
		expect_read(16'h82B8, 8'h00);
	endtask

	task automatic timer_clear_and_count();
		logic [7:0] got;
		int clocks;
		// Let the timer count away from zero so the clear has work to do
		clocks = 0;
		got = 8'h00;
		while (got == 8'h00 && clocks < 48000)
		begin
			read_bus(16'h802A, got);
			clocks++;
		end
		assert (got != 8'h00)
		else
		begin
			$display("timer low byte stayed 0 for 48000 clocks");
			abort_run();
		end
		write_bus(16'h802A, 8'h5A);
		expect_read(16'h802A, 8'h00);
		expect_read(16'h802B, 8'h00);
		clocks = 2;
		got = 8'h00;
		while (got != 8'h01 && clocks < 48000)
		begin
			read_bus(16'h802A, got);
			clocks++;
		end
		assert (got == 8'h01)
		else
		begin
			$display("timer low byte did not reach 1 within 48000 clocks");
			abort_run();
		end
		assert (clocks >= 24000)
		else
		begin
			$display("timer reached 1 after only %0d clocks", clocks);
			abort_run();
		end
	endtask

	task automatic wait_cpu_wait(input logic level, input string what);
		int n;
		n = 0;
		while (cpu_wait !== level && n < 16)
		begin
			tick();
			n++;
		end
		assert (cpu_wait === level)
		else
		begin
			$display("cpu_wait did not %s within 16 clocks", what);
			abort_run();
		end
	endtask

	task automatic pause_menu_triggers();
		check_hex("cpu_wait", {31'd0, cpu_wait}, 32'd0);
		write_bus(16'h82B6, 8'h01);
		wait_cpu_wait(1'b1, "rise after the pause write");
		// The trigger holds until pause clears it
		repeat (4) tick();
		check_hex("cpu_wait", {31'd0, cpu_wait}, 32'd1);
		pause = 1'b1;
		tick();
		pause = 1'b0;
		wait_cpu_wait(1'b0, "fall after the pause pulse");
		expect_read(16'h82B7, 8'h00);
		menu = 1'b1;
		tick();
		menu = 1'b0;
		expect_read(16'h82B7, 8'hFF);
		write_bus(16'h82B7, 8'h00);
		expect_read(16'h82B7, 8'h00);
	endtask

	// Raster outputs and ce_6 are both settled at the falling edge
	task automatic wait_hs_rise();
		logic prev;
		int n;
		n = 0;
		@(negedge clk_24);
		prev = vga_hs;
		@(negedge clk_24);
		while (!(vga_hs && !prev) && n < 2 * line_clocks)
		begin
			prev = vga_hs;
			@(negedge clk_24);
			n++;
		end
		assert (vga_hs && !prev)
		else
		begin
			$display("no rising edge on vga_hs within two lines");
			abort_run();
		end
	endtask

	task automatic raster_timing();
		int clocks;
		int hb_pulses;
		logic prev;
		wait_hs_rise();
		for (int line = 0; line < 3; line++)
		begin
			clocks = 0;
			hb_pulses = 0;
			do
			begin
				if (ce_6 && vga_hb)
					hb_pulses++;
				prev = vga_hs;
				@(negedge clk_24);
				clocks++;
			end
			while (!(vga_hs && !prev) && clocks < 2 * line_clocks);
			check_hex("vga_hs period", clocks, line_clocks);
			check_hex("vga_hb pulses", hb_pulses, 32'd61);
		end
		tick();
	endtask

	task automatic scan_frames(input int frames, input logic dark, output logic lit);
		int vs_clocks;
		int vb_clocks;
		lit = 1'b0;
		vs_clocks = 0;
		vb_clocks = 0;
		for (int n = 0; n < frames * frame_clocks; n++)
		begin
			@(negedge clk_24);
			check_hex("vga_g", {24'd0, vga_g}, {24'd0, vga_r});
			check_hex("vga_b", {24'd0, vga_b}, {24'd0, vga_r});
			if (dark || vga_hb || vga_vb)
				check_hex("vga_r", {24'd0, vga_r}, 32'd0);
			lit = lit || (vga_r != 8'h00);
			if (vga_vs)
				vs_clocks++;
			if (vga_vb)
				vb_clocks++;
		end
		// Each frame of 262 lines holds 3 sync lines and 22 blank lines
		check_hex("vga_vs high clocks", vs_clocks, frames * 3 * line_clocks);
		check_hex("vga_vb high clocks", vb_clocks, frames * 22 * line_clocks);
		tick();
	endtask

	task automatic starfield_mixing();
		logic lit;
		write_bus(16'h8286, 8'h00);
		write_bus(16'h8296, 8'h00);
		write_bus(16'h82A6, 8'h00);
		scan_frames(1, 1'b1, lit);
		write_bus(16'h8286, 8'h01);
		scan_frames(2, 1'b0, lit);
		assert (lit)
		else
		begin
			$display("no lit pixel within two frames after layer 1 was enabled");
			abort_run();
		end
	endtask

	initial
	begin
		seed = 62;
		arst_n = 1'b0;
		pause = 1'b0;
		menu = 1'b0;
		cpu_addr = 16'h0000;
		cpu_dout = 8'h00;
		cpu_wr_n = 1'b1;
		joystick = '0;
		paddle = '0;
		ps2_key = '0;
		timestamp = '0;
		repeat (8) @(posedge clk_24);
		#1;
		arst_n = 1'b1;
		check_hex("cpu_din", {24'd0, cpu_din}, 32'd0);
		check_hex("cpu_wait", {31'd0, cpu_wait}, 32'd0);
		ram_readback();
		input_map_reads();
		timer_clear_and_count();
		pause_menu_triggers();
		raster_timing();
		starfield_mixing();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: common/aznable_pkg.sv
`default_nettype none

package aznable_pkg;

	// CPU bus
	localparam int addr_w = 16;
	localparam int data_w = 8;
	localparam int wkram_aw = 14;

	// Input map, each region runs up to the start of the next
	localparam logic [addr_w-1:0] map_in0 = 16'h8000;
	localparam logic [addr_w-1:0] map_timestamp = 16'h8002;
	localparam logic [addr_w-1:0] map_timer = 16'h802A;
	localparam logic [addr_w-1:0] map_joystick = 16'h803A;
	localparam logic [addr_w-1:0] map_analog_l = 16'h80FA;
	localparam logic [addr_w-1:0] map_paddle = 16'h81BA;
	localparam logic [addr_w-1:0] map_spinner = 16'h81EA;
	localparam logic [addr_w-1:0] map_ps2_key = 16'h824A;
	localparam logic [addr_w-1:0] map_ps2_mouse = 16'h8256;
	localparam logic [addr_w-1:0] map_starfield1 = 16'h8286;
	localparam logic [addr_w-1:0] map_starfield2 = 16'h8296;
	localparam logic [addr_w-1:0] map_starfield3 = 16'h82A6;
	localparam logic [addr_w-1:0] map_system_pause = 16'h82B6;
	localparam logic [addr_w-1:0] map_system_menu = 16'h82B7;
	localparam logic [addr_w-1:0] map_wkram = 16'hC000;

	// Raster, in 6 MHz pixels and lines
	localparam int cnt_w = 9;
	localparam logic [cnt_w-1:0] h_total = 9'd381;
	localparam logic [cnt_w-1:0] v_total = 9'd262;
	localparam logic [cnt_w-1:0] h_visible = 9'd320;
	localparam logic [cnt_w-1:0] v_visible = 9'd240;
	localparam logic [cnt_w-1:0] h_sync_start = 9'd336;
	localparam logic [cnt_w-1:0] h_sync_end = 9'd368;
	localparam logic [cnt_w-1:0] v_sync_start = 9'd244;
	localparam logic [cnt_w-1:0] v_sync_end = 9'd247;

	// Pixels in one frame
	localparam int frame_w = 17;
	localparam logic [frame_w-1:0] frame_pixels = {8'd0, h_total} * {8'd0, v_total};

	// Millisecond timer at 24 MHz
	localparam int presc_w = 15;
	localparam logic [presc_w-1:0] ms_divider = 15'd24000;
	localparam int timer_w = 16;

	// Input words
	localparam int joystick_w = 192;
	localparam int paddle_w = 48;
	localparam int timestamp_w = 33;
	localparam int ps2_key_w = 11;

	// Star layers
	localparam int sf1_len = 22;
	localparam logic [sf1_len-1:0] sf1_seed = 22'h1FFFFF;
	localparam logic [sf1_len-1:0] sf1_mask = 22'b0000111100001111000011;
	localparam logic [sf1_len-1:0] sf1_taps = 22'b1100000000000000000000;
	localparam int sf2_len = 21;
	localparam logic [sf2_len-1:0] sf2_seed = 21'h1FFFF0;
	localparam logic [sf2_len-1:0] sf2_mask = 21'b000011110000111100001;
	localparam logic [sf2_len-1:0] sf2_taps = 21'b101010000000000000000;
	localparam int sf3_len = 21;
	localparam logic [sf3_len-1:0] sf3_seed = 21'h1FFF00;
	localparam logic [sf3_len-1:0] sf3_mask = 21'b000011110000111100001;
	localparam logic [sf3_len-1:0] sf3_taps = 21'b101000000000000000000;

endpackage

`default_nettype wire

// File: hdl/ms_timer.sv
`timescale 1ns/1ps
`default_nettype none

module ms_timer (
	input wire clk_24,
	input wire arst_n,
	input wire timer_clear,
	output logic [aznable_pkg::timer_w-1:0] timer
);

	logic [aznable_pkg::presc_w-1:0] presc;
	logic ms_tick;

	assign ms_tick = presc == aznable_pkg::ms_divider - 1'b1;

	// Clear restarts the whole millisecond, not just the count
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			presc <= '0;
			timer <= '0;
		end
		else if (timer_clear)
		begin
			presc <= '0;
			timer <= '0;
		end
		else if (ms_tick)
		begin
			presc <= '0;
			timer <= timer + 1'b1;
		end
		else
			presc <= presc + 1'b1;
	end

endmodule

`default_nettype wire

// File: hdl/system.sv
`timescale 1ns/1ps
`default_nettype none

module system (
	input wire clk_24,
	input wire arst_n,
	input wire ce_6,
	input wire pause,
	input wire menu,
	input wire [aznable_pkg::addr_w-1:0] cpu_addr,
	input wire [aznable_pkg::data_w-1:0] cpu_dout,
	input wire cpu_wr_n,
	input wire [aznable_pkg::joystick_w-1:0] joystick,
	input wire [aznable_pkg::paddle_w-1:0] paddle,
	input wire [aznable_pkg::ps2_key_w-1:0] ps2_key,
	input wire [aznable_pkg::timestamp_w-1:0] timestamp,
	output wire [aznable_pkg::data_w-1:0] cpu_din,
	output wire cpu_wait,
	output wire vga_hs,
	output wire vga_vs,
	output wire vga_hb,
	output wire vga_vb,
	output wire [7:0] vga_r,
	output wire [7:0] vga_g,
	output wire [7:0] vga_b
);

	wire [aznable_pkg::timer_w-1:0] timer;
	wire timer_clear;
	wire wkram_we;
	wire [aznable_pkg::data_w-1:0] wkram_q;
	wire pause_system;
	wire sf_write;
	wire [2:0] sf_sel;
	wire [2:0] sf_addr;
	wire sf_on1;
	wire sf_on2;
	wire sf_on3;
	wire [7:0] sf_star1;
	wire [7:0] sf_star2;
	wire [7:0] sf_star3;

	// Raster counters only feed blanking and sync here
	video_timer i_video_timer (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.ce_6(ce_6),
		.hcnt(),
		.vcnt(),
		.hblank(vga_hb),
		.vblank(vga_vb),
		.hsync(vga_hs),
		.vsync(vga_vs)
	);

	ms_timer i_ms_timer (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.timer_clear(timer_clear),
		.timer(timer)
	);

	io_map i_io_map (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_wr_n(cpu_wr_n),
		.pause(pause),
		.menu(menu),
		.hsync(vga_hs),
		.vsync(vga_vs),
		.hblank(vga_hb),
		.vblank(vga_vb),
		.timer(timer),
		.wkram_q(wkram_q),
		.joystick(joystick),
		.paddle(paddle),
		.ps2_key(ps2_key),
		.timestamp(timestamp),
		.cpu_din(cpu_din),
		.pause_system(pause_system),
		.timer_clear(timer_clear),
		.wkram_we(wkram_we),
		.sf_write(sf_write),
		.sf_sel(sf_sel),
		.sf_addr(sf_addr)
	);

	assign cpu_wait = pause_system;

	// 0xC000 to 0xFFFF
	work_ram i_work_ram (
		.clk_24(clk_24),
		.wkram_addr(cpu_addr[aznable_pkg::wkram_aw-1:0]),
		.wkram_we(wkram_we),
		.wkram_d(cpu_dout),
		.wkram_q(wkram_q)
	);

	starfield #(
		.lfsr_len(aznable_pkg::sf1_len),
		.seed(aznable_pkg::sf1_seed),
		.mask(aznable_pkg::sf1_mask),
		.taps(aznable_pkg::sf1_taps)
	) stars1 (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.ce_6(ce_6),
		.pause_system(pause_system),
		.sf_write(sf_write),
		.sf_sel_hit(sf_sel[0]),
		.sf_addr(sf_addr),
		.cpu_dout(cpu_dout),
		.sf_on(sf_on1),
		.sf_star(sf_star1)
	);

	starfield #(
		.lfsr_len(aznable_pkg::sf2_len),
		.seed(aznable_pkg::sf2_seed),
		.mask(aznable_pkg::sf2_mask),
		.taps(aznable_pkg::sf2_taps)
	) stars2 (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.ce_6(ce_6),
		.pause_system(pause_system),
		.sf_write(sf_write),
		.sf_sel_hit(sf_sel[1]),
		.sf_addr(sf_addr),
		.cpu_dout(cpu_dout),
		.sf_on(sf_on2),
		.sf_star(sf_star2)
	);

	starfield #(
		.lfsr_len(aznable_pkg::sf3_len),
		.seed(aznable_pkg::sf3_seed),
		.mask(aznable_pkg::sf3_mask),
		.taps(aznable_pkg::sf3_taps)
	) stars3 (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.ce_6(ce_6),
		.pause_system(pause_system),
		.sf_write(sf_write),
		.sf_sel_hit(sf_sel[2]),
		.sf_addr(sf_addr),
		.cpu_dout(cpu_dout),
		.sf_on(sf_on3),
		.sf_star(sf_star3)
	);

	video_mixer i_video_mixer (
		.sf_on1(sf_on1),
		.sf_star1(sf_star1),
		.sf_on2(sf_on2),
		.sf_star2(sf_star2),
		.sf_on3(sf_on3),
		.sf_star3(sf_star3),
		.hblank(vga_hb),
		.vblank(vga_vb),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

`default_nettype wire

// File: hdl/video_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module video_mixer (
	input wire sf_on1,
	input wire [7:0] sf_star1,
	input wire sf_on2,
	input wire [7:0] sf_star2,
	input wire sf_on3,
	input wire [7:0] sf_star3,
	input wire hblank,
	input wire vblank,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	logic [7:0] shade;
	logic de;

	// Farther layers are dimmer
	always_comb
	begin
		if (sf_on1)
			shade = sf_star1;
		else if (sf_on2)
			shade = {1'b0, sf_star2[6:0]};
		else if (sf_on3)
			shade = {2'b00, sf_star3[5:0]};
		else
			shade = 8'h00;
	end

	assign de = !(hblank || vblank);

	// Stars are grey
	assign vga_r = de ? shade : 8'h00;
	assign vga_g = de ? shade : 8'h00;
	assign vga_b = de ? shade : 8'h00;

endmodule

`default_nettype wire

// File: hdl/video_timer.sv
`timescale 1ns/1ps
`default_nettype none

module video_timer (
	input wire clk_24,
	input wire arst_n,
	input wire ce_6,
	output logic [aznable_pkg::cnt_w-1:0] hcnt,
	output logic [aznable_pkg::cnt_w-1:0] vcnt,
	output logic hblank,
	output logic vblank,
	output logic hsync,
	output logic vsync
);

	logic line_end;
	logic frame_end;

	assign line_end = hcnt == aznable_pkg::h_total - 9'd1;
	assign frame_end = vcnt == aznable_pkg::v_total - 9'd1;

	// Raster counters step once per pixel
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hcnt <= '0;
			vcnt <= '0;
		end
		else if (ce_6)
		begin
			if (line_end)
			begin
				hcnt <= '0;
				vcnt <= frame_end ? '0 : vcnt + 1'b1;
			end
			else
				hcnt <= hcnt + 1'b1;
		end
	end

	// Blanking covers everything past the visible area
	assign hblank = hcnt >= aznable_pkg::h_visible;
	assign vblank = vcnt >= aznable_pkg::v_visible;

	assign hsync = hcnt >= aznable_pkg::h_sync_start && hcnt < aznable_pkg::h_sync_end;
	assign vsync = vcnt >= aznable_pkg::v_sync_start && vcnt < aznable_pkg::v_sync_end;

endmodule

`default_nettype wire

// File: hdl/work_ram.sv
`timescale 1ns/1ps
`default_nettype none

module work_ram (
	input wire clk_24,
	input wire [aznable_pkg::wkram_aw-1:0] wkram_addr,
	input wire wkram_we,
	input wire [aznable_pkg::data_w-1:0] wkram_d,
	output logic [aznable_pkg::data_w-1:0] wkram_q
);

	logic [aznable_pkg::data_w-1:0] mem [0:(2**aznable_pkg::wkram_aw)-1];

	// Read returns the old byte on a write to the same address
	always_ff @(posedge clk_24)
	begin
		if (wkram_we)
			mem[wkram_addr] <= wkram_d;
		wkram_q <= mem[wkram_addr];
	end

endmodule

`default_nettype wire

// File: io/io_map.sv
`timescale 1ns/1ps
`default_nettype none

module io_map (
	input wire clk_24,
	input wire arst_n,
	input wire [aznable_pkg::addr_w-1:0] cpu_addr,
	input wire [aznable_pkg::data_w-1:0] cpu_dout,
	input wire cpu_wr_n,
	input wire pause,
	input wire menu,
	input wire hsync,
	input wire vsync,
	input wire hblank,
	input wire vblank,
	input wire [aznable_pkg::timer_w-1:0] timer,
	input wire [aznable_pkg::data_w-1:0] wkram_q,
	input wire [aznable_pkg::joystick_w-1:0] joystick,
	input wire [aznable_pkg::paddle_w-1:0] paddle,
	input wire [aznable_pkg::ps2_key_w-1:0] ps2_key,
	input wire [aznable_pkg::timestamp_w-1:0] timestamp,
	output logic [aznable_pkg::data_w-1:0] cpu_din,
	output logic pause_system,
	output logic timer_clear,
	output logic wkram_we,
	output logic sf_write,
	output logic [2:0] sf_sel,
	output logic [2:0] sf_addr
);

	wire wr = !cpu_wr_n;

	// Region decode
	wire in0_cs = cpu_addr == aznable_pkg::map_in0;
	wire timestamp_cs = cpu_addr >= aznable_pkg::map_timestamp
		&& cpu_addr < aznable_pkg::map_timer;
	wire timer_cs = cpu_addr >= aznable_pkg::map_timer && cpu_addr < aznable_pkg::map_joystick;
	wire joystick_cs = cpu_addr >= aznable_pkg::map_joystick
		&& cpu_addr < aznable_pkg::map_analog_l;
	wire paddle_cs = cpu_addr >= aznable_pkg::map_paddle && cpu_addr < aznable_pkg::map_spinner;
	wire ps2_key_cs = cpu_addr >= aznable_pkg::map_ps2_key
		&& cpu_addr < aznable_pkg::map_ps2_mouse;
	wire sf1_cs = cpu_addr >= aznable_pkg::map_starfield1
		&& cpu_addr < aznable_pkg::map_starfield2;
	wire sf2_cs = cpu_addr >= aznable_pkg::map_starfield2
		&& cpu_addr < aznable_pkg::map_starfield3;
	wire sf3_cs = cpu_addr >= aznable_pkg::map_starfield3
		&& cpu_addr < aznable_pkg::map_system_pause;
	wire system_pause_cs = cpu_addr == aznable_pkg::map_system_pause;
	wire system_menu_cs = cpu_addr == aznable_pkg::map_system_menu;
	wire wkram_cs = cpu_addr >= aznable_pkg::map_wkram;

	// Byte offsets into each region
	wire [15:0] timestamp_off = cpu_addr - aznable_pkg::map_timestamp;
	wire [15:0] timer_off = cpu_addr - aznable_pkg::map_timer;
	wire [15:0] joystick_off = cpu_addr - aznable_pkg::map_joystick;
	wire [15:0] paddle_off = cpu_addr - aznable_pkg::map_paddle;
	wire [15:0] ps2_key_off = cpu_addr - aznable_pkg::map_ps2_key;

	// Input words zero extended to whole bytes of the offset range
	wire [63:0] timestamp_pad = {{(64 - aznable_pkg::timestamp_w){1'b0}}, timestamp};
	wire [255:0] joystick_pad = {{(256 - aznable_pkg::joystick_w){1'b0}}, joystick};
	wire [63:0] paddle_pad = {{(64 - aznable_pkg::paddle_w){1'b0}}, paddle};
	wire [15:0] ps2_key_pad = {{(16 - aznable_pkg::ps2_key_w){1'b0}}, ps2_key};

	logic pause_trigger;
	logic menu_trigger;
	logic [aznable_pkg::data_w-1:0] rd_byte;
	logic [aznable_pkg::data_w-1:0] rd_q;
	logic ram_rd;

	// Star layer registers share one offset, sf_sel picks the layer
	wire [15:0] sf_base = sf1_cs ? aznable_pkg::map_starfield1 :
		sf2_cs ? aznable_pkg::map_starfield2 : aznable_pkg::map_starfield3;
	wire [15:0] sf_off = cpu_addr - sf_base;

	assign sf_sel = {sf3_cs, sf2_cs, sf1_cs};
	assign sf_write = wr && (sf1_cs || sf2_cs || sf3_cs);
	assign sf_addr = sf_off[2:0];

	assign timer_clear = wr && timer_cs;
	assign wkram_we = wr && wkram_cs;

	// Pause from outside always wins over the CPU trigger
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pause_trigger <= 1'b0;
			menu_trigger <= 1'b0;
		end
		else
		begin
			if (pause)
				pause_trigger <= 1'b0;
			else if (wr && system_pause_cs)
				pause_trigger <= 1'b1;
			// CPU acknowledges the menu request by writing it
			if (wr && system_menu_cs)
				menu_trigger <= 1'b0;
			else if (menu)
				menu_trigger <= 1'b1;
		end
	end

	assign pause_system = pause || pause_trigger;

	// Read mux, unmapped addresses give zero
	always_comb
	begin
		rd_byte = '0;
		if (in0_cs)
			rd_byte = {hsync, vsync, hblank, vblank, 2'b10, menu, 1'b0};
		else if (timestamp_cs)
			rd_byte = timestamp_pad[{timestamp_off[2:0], 3'b000} +: 8];
		else if (timer_cs)
			rd_byte = timer[{timer_off[0], 3'b000} +: 8];
		else if (joystick_cs)
			rd_byte = joystick_pad[{joystick_off[4:0], 3'b000} +: 8];
		else if (paddle_cs)
			rd_byte = paddle_pad[{paddle_off[2:0], 3'b000} +: 8];
		else if (ps2_key_cs)
			rd_byte = ps2_key_pad[{ps2_key_off[0], 3'b000} +: 8];
		else if (system_menu_cs)
			rd_byte = {8{menu_trigger}};
	end

	// Work RAM already holds its read data one cycle, the rest is registered here
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_q <= '0;
			ram_rd <= 1'b0;
		end
		else
		begin
			rd_q <= rd_byte;
			ram_rd <= wkram_cs;
		end
	end

	assign cpu_din = ram_rd ? wkram_q : rd_q;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_system -o tb_system
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_system)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
	exit 0
else
	exit 1
fi

// File: starfield/starfield.sv
`timescale 1ns/1ps
`default_nettype none

module starfield #(
	parameter int lfsr_len = 22,
	parameter logic [lfsr_len-1:0] seed = '1,
	parameter logic [lfsr_len-1:0] mask = '0,
	parameter logic [lfsr_len-1:0] taps = '0
) (
	input wire clk_24,
	input wire arst_n,
	input wire ce_6,
	input wire pause_system,
	input wire sf_write,
	input wire sf_sel_hit,
	input wire [2:0] sf_addr,
	input wire [aznable_pkg::data_w-1:0] cpu_dout,
	output logic sf_on,
	output logic [7:0] sf_star
);

	logic enable;
	logic [lfsr_len-1:0] lfsr;
	logic [aznable_pkg::frame_w-1:0] pix_cnt;
	logic frame_end;

	// Pixel position within the frame, in step with the raster counters from reset
	assign frame_end = ce_6 && pix_cnt == aznable_pkg::frame_pixels - 1'b1;

	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			pix_cnt <= '0;
		else if (frame_end)
			pix_cnt <= '0;
		else if (ce_6)
			pix_cnt <= pix_cnt + 1'b1;
	end

	// Layer enable at offset 0, bit 0
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			enable <= 1'b0;
		else if (sf_write && sf_sel_hit && sf_addr == 3'd0)
			enable <= cpu_dout[0];
	end

	// Reloading the seed every frame keeps the star pattern in place
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			lfsr <= seed;
		else if (frame_end)
			lfsr <= seed;
		else if (ce_6 && enable && !pause_system)
			lfsr <= {lfsr[lfsr_len-2:0], ^(lfsr & taps)};
	end

	// A star shows where every masked bit is set
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			sf_on <= 1'b0;
		else
			sf_on <= enable && &(lfsr | ~mask);
	end

	always_ff @(posedge clk_24)
	begin
		sf_star <= lfsr[7:0];
	end

endmodule

`default_nettype wire

// File: verilog.f
common/aznable_pkg.sv
hdl/video_timer.sv
hdl/ms_timer.sv
hdl/work_ram.sv
io/io_map.sv
starfield/starfield.sv
hdl/video_mixer.sv
hdl/system.sv
bench/tb_system.sv
